// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_spi_bridge
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bridge_ctrl.sv ====
// first byte of a pair is the SPI address, second the data
// a pair that completes while SPI is busy is lost; a reply that finds the FIFO full is lost
`timescale 1ns/10ps
module bridge_ctrl
  import uart_pkg::*, spi_pkg::*;
(
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       rx_valid_i,
  input  uart_byte_t rx_byte_i,
  spi_xfer_if.ctrl   xfer,
  byte_fifo_if.ctrl  q,
  input  logic       tx_busy_i,
  output logic       tx_start_o,
  output uart_byte_t tx_byte_o
);

  // last two bytes, older one on top
  spi_word_t pair_r;
  // set after the address byte
  logic      odd_r;
  logic      start_r;
  // FIFO read issued last cycle
  logic      rd_pend_r;

  ////////////////////////////////////////
  // UART bytes into SPI words
  ////////////////////////////////////////

  // every byte shifts in, so the word is always the latest pair
  always_ff @(posedge fpga_clk) begin
    if (rx_valid_i) begin
      pair_r <= {pair_r[UART_DATA_BITS-1:0], rx_byte_i};
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      odd_r     <= 1'b0;
      start_r   <= 1'b0;
      rd_pend_r <= 1'b0;
    end else begin
      // launch on the second byte, the cycle after it lands
      start_r <= rx_valid_i && odd_r && !xfer.busy;
      if (rx_valid_i) begin
        odd_r <= ~odd_r;
      end
      rd_pend_r <= q.rd_en;
    end
  end

  assign xfer.start = start_r;
  assign xfer.word  = pair_r;

  ////////////////////////////////////////
  // replies through the FIFO to UART
  ////////////////////////////////////////

  // queue the reply in the done cycle
  assign q.wr_en   = xfer.done && !q.full;
  assign q.wr_data = xfer.rx_byte;

  // one read per frame, pending read blocks a second one
  // until the transmitter shows busy
  assign q.rd_en = !q.empty && !tx_busy_i && !rd_pend_r;

  // rd_data is valid now, start the frame
  assign tx_start_o = rd_pend_r;
  assign tx_byte_o  = q.rd_data;

endmodule

// ==== bridge_ifs.sv ====
// strobes are one cycle wide; start is only looked at while busy is low
// FIFO rd_data shows up the cycle after rd_en
`timescale 1ns/10ps

////////////////////////////////////////
// controller to SPI master
////////////////////////////////////////
interface spi_xfer_if
  import uart_pkg::*, spi_pkg::*;
();
  // launch strobe, word taken on it
  logic       start;
  spi_word_t  word;
  // high from the cycle after start up to done
  logic       busy;
  logic       done;
  // byte clocked in during the data half
  uart_byte_t rx_byte;

  modport ctrl (output start, output word, input busy, input done, input rx_byte);
  modport master (input start, input word, output busy, output done, output rx_byte);
endinterface

////////////////////////////////////////
// controller to reply FIFO
////////////////////////////////////////
interface byte_fifo_if
  import uart_pkg::*;
();
  // write side
  logic       wr_en;
  uart_byte_t wr_data;
  logic       full;
  // read side
  logic       rd_en;
  uart_byte_t rd_data;
  logic       empty;

  modport ctrl (output wr_en, output wr_data, output rd_en, input full, input empty, input rd_data);
  modport fifo (input wr_en, input wr_data, input rd_en, output full, output empty, output rd_data);
endinterface

// ==== byte_fifo.sv ====
// DEPTH must be a power of two; writes when full and reads when empty are ignored
// rd_data is registered and holds its value until the next accepted read
`timescale 1ns/10ps
module byte_fifo
  import uart_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic      fpga_clk,
  input  logic      reset_all_cmd_w,
  byte_fifo_if.fifo q
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  uart_byte_t       mem_r [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             wr_ok_w;
  logic             rd_ok_w;

  // flags straight from occupancy
  assign q.full  = (count_r == CNT_W'(DEPTH));
  assign q.empty = (count_r == '0);

  assign wr_ok_w = q.wr_en && !q.full;
  assign rd_ok_w = q.rd_en && !q.empty;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      // pointers wrap at DEPTH
      if (wr_ok_w) begin
        wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (rd_ok_w) begin
        rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      // simultaneous read and write leaves count alone
      case ({wr_ok_w, rd_ok_w})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // storage and read port
  always_ff @(posedge fpga_clk) begin
    if (wr_ok_w) begin
      mem_r[wr_ptr_r] <= q.wr_data;
    end
    if (rd_ok_w) begin
      q.rd_data <= mem_r[rd_ptr_r];
    end
  end

endmodule

// ==== project.f ====
uart_pkg.sv
spi_pkg.sv
bridge_ifs.sv
uart_rx.sv
uart_tx.sv
spi_master.sv
byte_fifo.sv
bridge_ctrl.sv
spi_bridge_top.sv
tb_clock_gen.sv
tb_spi_bridge.sv

// ==== spi_bridge_top.sv ====
// PC bytes in on UART, paired into 16-bit SPI writes, SOUT replies back out on UART
// one SPI word in flight, up to four replies waiting on the transmitter
`timescale 1ns/10ps
module spi_bridge_top
  import uart_pkg::*;
(
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  input  logic spi_sout_i,
  output logic uart_tx_o,
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_sdat_o
);

  // receiver to controller
  logic       rx_valid_w;
  uart_byte_t rx_byte_w;
  // controller to transmitter
  logic       tx_start_w;
  uart_byte_t tx_byte_w;
  logic       tx_busy_w;

  spi_xfer_if  xfer_if ();
  byte_fifo_if fifo_if ();

  ////////////////////////////////////////
  // UART side
  ////////////////////////////////////////
  uart_rx i_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid_w),
    .rx_byte_o       (rx_byte_w)
  );

  uart_tx i_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start_w),
    .tx_byte_i       (tx_byte_w),
    .tx_serial_o     (uart_tx_o),
    .tx_busy_o       (tx_busy_w)
  );

  ////////////////////////////////////////
  // control, SPI and reply queue
  ////////////////////////////////////////
  bridge_ctrl i_bridge_ctrl (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid_w),
    .rx_byte_i       (rx_byte_w),
    .xfer            (xfer_if),
    .q               (fifo_if),
    .tx_busy_i       (tx_busy_w),
    .tx_start_o      (tx_start_w),
    .tx_byte_o       (tx_byte_w)
  );

  spi_master i_spi_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .xfer            (xfer_if),
    .spi_sout_i      (spi_sout_i),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_sdat_o      (spi_sdat_o)
  );

  // default depth of four
  byte_fifo i_byte_fifo (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .q               (fifo_if)
  );

endmodule

// ==== spi_master.sv ====
// mode 0, MSB first; one word per start, SEN low over the whole word
// start to done is 4 * SPI_HALF_PERIOD * 8 + 2 cycles, 66 at the default settings
`timescale 1ns/10ps
module spi_master
  import uart_pkg::*, spi_pkg::*;
(
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  spi_xfer_if.master xfer,
  input  logic       spi_sout_i,
  output logic       spi_sen_o,
  output logic       spi_sck_o,
  output logic       spi_sdat_o
);

  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_HOLD} spi_state_t;

  spi_state_t                state_r;
  logic [SPI_HP_CNT_W-1:0]   hp_cnt_r;
  logic [SPI_HALF_CNT_W-1:0] half_cnt_r;
  spi_word_t                 tx_shift_r;
  uart_byte_t                rx_shift_r;
  logic                      half_end_w;
  logic                      last_half_w;

  // end of one SCK half period
  assign half_end_w  = (hp_cnt_r == SPI_HP_CNT_W'(SPI_HALF_PERIOD - 1));
  // final high half of the last bit
  assign last_half_w = (half_cnt_r == SPI_HALF_CNT_W'(2 * SPI_WORD_BITS - 1));

  // last eight samples, the data half
  assign xfer.rx_byte = rx_shift_r;

  ////////////////////////////////////////
  // sequencing and pins
  ////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_r    <= SPI_IDLE;
      hp_cnt_r   <= '0;
      half_cnt_r <= '0;
      spi_sen_o  <= 1'b1;
      spi_sck_o  <= 1'b0;
      spi_sdat_o <= 1'b0;
      xfer.busy  <= 1'b0;
      xfer.done  <= 1'b0;
    end else begin
      xfer.done <= 1'b0;
      case (state_r)
        SPI_IDLE: begin
          hp_cnt_r   <= '0;
          half_cnt_r <= '0;
          if (xfer.start) begin
            // first bit set up before the first rising edge
            spi_sen_o  <= 1'b0;
            spi_sdat_o <= xfer.word[SPI_WORD_BITS-1];
            xfer.busy  <= 1'b1;
            state_r    <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_end_w) begin
            hp_cnt_r   <= '0;
            half_cnt_r <= half_cnt_r + 1'b1;
            spi_sck_o  <= ~spi_sck_o;
            // falling edge, next bit out
            if (spi_sck_o) begin
              if (last_half_w) begin
                spi_sdat_o <= 1'b0;
                state_r    <= SPI_HOLD;
              end else begin
                spi_sdat_o <= tx_shift_r[SPI_WORD_BITS-2];
              end
            end
          end else begin
            hp_cnt_r <= hp_cnt_r + 1'b1;
          end
        end
        SPI_HOLD: begin
          // one cycle with SCK low before SEN rises
          spi_sen_o <= 1'b1;
          xfer.busy <= 1'b0;
          xfer.done <= 1'b1;
          state_r   <= SPI_IDLE;
        end
        default: state_r <= SPI_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // shift registers
  ////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if ((state_r == SPI_IDLE) && xfer.start) begin
      tx_shift_r <= xfer.word;
    end else if ((state_r == SPI_SHIFT) && half_end_w && spi_sck_o) begin
      tx_shift_r <= tx_shift_r << 1;
    end
    // sample SOUT as SCK goes high
    if ((state_r == SPI_SHIFT) && half_end_w && !spi_sck_o) begin
      rx_shift_r <= {rx_shift_r[UART_DATA_BITS-2:0], spi_sout_i};
    end
  end

endmodule

// ==== spi_pkg.sv ====
// mode 0 only, MSB first, chip select framed around one whole word
// SPI_HALF_PERIOD of 1 gives the fastest SCK, fpga_clk / 2
package spi_pkg;

  ////////////////////////////////////////
  // SCK timing
  ////////////////////////////////////////

  // fpga_clk cycles per SCK half period
  localparam int SPI_HALF_PERIOD = 2;
  // half period counter, kept at least one bit wide
  localparam int SPI_HP_CNT_W = (SPI_HALF_PERIOD > 1) ? $clog2(SPI_HALF_PERIOD) : 1;

  ////////////////////////////////////////
  // word layout
  ////////////////////////////////////////

  // address byte plus data byte
  localparam int SPI_WORD_BITS = 16;
  // counts SCK half periods over one word
  localparam int SPI_HALF_CNT_W = $clog2(2 * SPI_WORD_BITS);

  // address in [15:8], data in [7:0]
  typedef logic [SPI_WORD_BITS-1:0] spi_word_t;

endpackage

// ==== tb_clock_gen.sv ====
// free running 100 ns clock, reset high over the first 3 rising edges
// reset_req_i stretches reset for resets in the middle of a run
`timescale 1ns/10ps
module tb_clock_gen (
  input  logic reset_req_i,
  output logic fpga_clk_o,
  output logic reset_all_cmd_o
);

  localparam int HALF_PERIOD_NS = 50;
  localparam int RESET_CYCLES = 3;

  // power-on part of reset
  logic por_r;

  initial begin
    fpga_clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) fpga_clk_o = ~fpga_clk_o;
  end

  // released just after an edge, like all other stimulus
  initial begin
    por_r = 1'b1;
    repeat (RESET_CYCLES) @(posedge fpga_clk_o);
    #1;
    por_r = 1'b0;
  end

  assign reset_all_cmd_o = por_r | reset_req_i;

endmodule

// ==== tb_spi_bridge.sv ====
// slave answers each data half with the address byte XOR 0x5A
// stimulus drains all replies before it asserts reset mid-run
`timescale 1ns/10ps
module tb_spi_bridge
  import uart_pkg::*, spi_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int RANDOM_PAIRS = 12;
  localparam int RANDOM_SEED = 94;

  logic fpga_clk;
  logic reset_all_cmd_w;
  logic reset_req;
  logic uart_rx;
  logic spi_sout;
  logic uart_tx;
  logic spi_sen;
  logic spi_sck;
  logic spi_sdat;

  // expected items, pushed when a pair goes out
  spi_word_t  exp_words[$];
  uart_byte_t exp_replies[$];
  // observed items from the slave and the monitor
  spi_word_t  obs_words[$];
  uart_byte_t obs_replies[$];

  // error counts, one per process
  int seq_errs = 0;
  int spi_errs = 0;
  int cmp_errs = 0;
  int uart_errs = 0;
  int total_errs;
  int frames_seen = 0;
  int frames_sent = 0;
  int cycle_cnt = 0;
  // pairing as the bridge should see it
  logic       pair_odd;
  uart_byte_t addr_hold;

  tb_clock_gen i_clock_gen (
    .reset_req_i     (reset_req),
    .fpga_clk_o      (fpga_clk),
    .reset_all_cmd_o (reset_all_cmd_w)
  );

  spi_bridge_top i_spi_bridge_top (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx),
    .spi_sout_i      (spi_sout),
    .uart_tx_o       (uart_tx),
    .spi_sen_o       (spi_sen),
    .spi_sck_o       (spi_sck),
    .spi_sdat_o      (spi_sdat)
  );

  ////////////////////////////////////////
  // reference and helpers
  ////////////////////////////////////////

  // slave reply rule
  function automatic uart_byte_t slave_reply(input uart_byte_t addr);
    return addr ^ 8'h5A;
  endfunction

  function automatic bit value_ok(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED at %0t: %s expected 'h%0h, got 'h%0h", $time, name, exp, act);
    end
    return (act === exp);
  endfunction

  // n edges, then just past the last one
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge fpga_clk);
    #1;
  endtask

  // start, eight bits LSB first, stop
  task automatic drive_frame(input uart_byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      wait_cycles(CLKS_PER_BIT);
    end
  endtask

  // every second byte makes a pair
  task automatic send_byte(input uart_byte_t b);
    if (pair_odd) begin
      exp_words.push_back({addr_hold, b});
      exp_replies.push_back(slave_reply(addr_hold));
      frames_sent++;
    end else begin
      addr_hold = b;
    end
    pair_odd = !pair_odd;
    drive_frame(b);
  endtask

  // until every sent pair has its word and reply
  task automatic wait_drained();
    while ((exp_words.size() != 0) || (exp_replies.size() != 0)) begin
      @(posedge fpga_clk);
    end
    #1;
  endtask

  task automatic check_idle_pins(input int n);
    repeat (n) begin
      wait_cycles(1);
      if (!value_ok("spi_sen_o", 1, 32'(spi_sen))) seq_errs++;
      if (!value_ok("spi_sck_o", 0, 32'(spi_sck))) seq_errs++;
      if (!value_ok("uart_tx_o", 1, 32'(uart_tx))) seq_errs++;
    end
  endtask

  task automatic pulse_reset();
    reset_req = 1'b1;
    wait_cycles(3);
    reset_req = 1'b0;
    pair_odd = 1'b0;
    wait_cycles(2);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial begin : stimulus
    uart_rx = 1'b1;
    reset_req = 1'b0;
    pair_odd = 1'b0;
    addr_hold = '0;
    void'($urandom(RANDOM_SEED));
    wait (!reset_all_cmd_w);
    wait_cycles(2);

    // quiet pins after reset
    check_idle_pins(60);

    // one known pair, one frame, one reply
    send_byte(8'h89);
    send_byte(8'h00);
    wait_drained();
    wait_cycles(100);
    if (!value_ok("spi frame count", 32'(frames_sent), 32'(frames_seen))) seq_errs++;

    // lone address byte then a gap
    send_byte(uart_byte_t'($urandom));
    wait_cycles(600);
    if (!value_ok("spi frame count", 32'(frames_sent), 32'(frames_seen))) seq_errs++;
    send_byte(uart_byte_t'($urandom));
    wait_drained();

    // back to back random pairs
    for (int p = 0; p < RANDOM_PAIRS; p++) begin
      send_byte(uart_byte_t'($urandom));
      send_byte(uart_byte_t'($urandom));
    end
    wait_drained();

    // reset after an odd byte, then a fresh pair
    send_byte(8'h3C);
    pulse_reset();
    check_idle_pins(10);
    send_byte(8'hA7);
    send_byte(8'h15);
    wait_drained();

    wait_cycles(200);
    if (!value_ok("spi frame count", 32'(frames_sent), 32'(frames_seen))) seq_errs++;

    total_errs = seq_errs + spi_errs + cmp_errs + uart_errs;
    $display("errors: sequence %0d, spi %0d, compare %0d, uart %0d, total %0d",
             seq_errs, spi_errs, cmp_errs, uart_errs, total_errs);
    if (total_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  ////////////////////////////////////////
  // SPI slave model
  ////////////////////////////////////////
  initial begin : spi_slave
    spi_word_t  shift_w;
    uart_byte_t reply_b;
    int         bit_cnt;
    logic       sck_prev;
    logic       in_frame;
    spi_sout = 1'b0;
    shift_w = '0;
    reply_b = '0;
    bit_cnt = 0;
    sck_prev = 1'b0;
    in_frame = 1'b0;
    forever begin
      @(posedge fpga_clk);
      #1;
      if (!in_frame && !spi_sen) begin
        in_frame = 1'b1;
        bit_cnt = 0;
      end
      // SDAT is stable across the SCK rise
      if (spi_sck && !sck_prev) begin
        assert (in_frame) else begin
          $display("spi_sck_o rose at %0t while spi_sen_o was high", $time);
        end
        if (!in_frame) begin
          spi_errs++;
        end else begin
          shift_w = {shift_w[SPI_WORD_BITS-2:0], spi_sdat};
          bit_cnt++;
          if (bit_cnt == 8) begin
            reply_b = slave_reply(shift_w[7:0]);
          end
          // next data bit, ready before the next rise
          if ((bit_cnt >= 8) && (bit_cnt < 16)) begin
            spi_sout = reply_b[15 - bit_cnt];
          end else begin
            spi_sout = 1'b0;
          end
        end
      end
      // SEN back high closes the frame
      if (in_frame && spi_sen) begin
        if (!value_ok("spi_sck_o rises per frame", 16, 32'(bit_cnt))) spi_errs++;
        obs_words.push_back(shift_w);
        frames_seen++;
        in_frame = 1'b0;
        spi_sout = 1'b0;
      end
      sck_prev = spi_sck;
    end
  end

  ////////////////////////////////////////
  // UART monitor
  ////////////////////////////////////////
  initial begin : uart_monitor
    uart_byte_t rx_b;
    rx_b = '0;
    forever begin
      @(posedge fpga_clk);
      #1;
      if (!reset_all_cmd_w && !uart_tx) begin
        // first low cycle, move to mid start bit
        repeat (CLKS_PER_BIT / 2) @(posedge fpga_clk);
        #1;
        if (!value_ok("uart_tx_o start bit", 0, 32'(uart_tx))) uart_errs++;
        for (int i = 0; i < UART_DATA_BITS; i++) begin
          wait_cycles(CLKS_PER_BIT);
          rx_b[i] = uart_tx;
        end
        wait_cycles(CLKS_PER_BIT);
        if (!value_ok("uart_tx_o stop bit", 1, 32'(uart_tx))) uart_errs++;
        obs_replies.push_back(rx_b);
      end
    end
  end

  ////////////////////////////////////////
  // compare, mid-cycle so pushes are done
  ////////////////////////////////////////
  always @(negedge fpga_clk) begin : compare
    spi_word_t  got_w;
    uart_byte_t got_b;
    if (obs_words.size() != 0) begin
      got_w = obs_words.pop_front();
      assert (exp_words.size() != 0) else begin
        $display("SPI frame with word %h at %0t but no pair was sent", got_w, $time);
      end
      if (exp_words.size() == 0) begin
        cmp_errs++;
      end else if (!value_ok("spi_sdat_o word", 32'(exp_words.pop_front()), 32'(got_w))) begin
        cmp_errs++;
      end
    end
    if (obs_replies.size() != 0) begin
      got_b = obs_replies.pop_front();
      assert (exp_replies.size() != 0) else begin
        $display("UART reply %h at %0t with no SPI frame behind it", got_b, $time);
      end
      if (exp_replies.size() == 0) begin
        cmp_errs++;
      end else if (!value_ok("uart_tx_o byte", 32'(exp_replies.pop_front()), 32'(got_b))) begin
        cmp_errs++;
      end
    end
  end

  // hang guard
  always @(posedge fpga_clk) begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d words and %0d replies still expected",
               cycle_cnt, exp_words.size(), exp_replies.size());
      $display("errors: sequence %0d, spi %0d, compare %0d, uart %0d, timeout 1",
               seq_errs, spi_errs, cmp_errs, uart_errs);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

// ==== uart_pkg.sv ====
// fixed 8N1 framing, no parity and no baud select at run time
// the bit counter width only covers CLKS_PER_BIT up to 32
package uart_pkg;

  ////////////////////////////////////////
  // line timing
  ////////////////////////////////////////

  // clocks per bit at the board rate
  localparam int CLKS_PER_BIT = 20;
  // counter width for one bit period
  localparam int UART_CLK_CNT_W = 5;

  ////////////////////////////////////////
  // frame layout
  ////////////////////////////////////////

  // data bits between start and stop
  localparam int UART_DATA_BITS = 8;
  // index over the data bits
  localparam int UART_BIT_IDX_W = $clog2(UART_DATA_BITS);

  // one byte on the wire, also one SPI half
  typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

endpackage

// ==== uart_rx.sv ====
// 8N1 only; a start bit gone high again at mid-bit counts as a glitch
// a bad stop bit drops the byte silently, there is no framing error flag
`timescale 1ns/10ps
module uart_rx
  import uart_pkg::*;
(
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       rx_serial_i,
  output logic       rx_valid_o,
  output uart_byte_t rx_byte_o
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t                 state_r;
  logic [UART_CLK_CNT_W-1:0] clk_cnt_r;
  logic [UART_BIT_IDX_W-1:0] bit_idx_r;
  logic                      rx_meta_r;
  logic                      rx_sync_r;
  logic                      bit_end_w;
  logic                      mid_start_w;

  // two flop sync, line idles high
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta_r <= 1'b1;
      rx_sync_r <= 1'b1;
    end else begin
      rx_meta_r <= rx_serial_i;
      rx_sync_r <= rx_meta_r;
    end
  end

  // full bit period elapsed
  assign bit_end_w   = (clk_cnt_r == UART_CLK_CNT_W'(CLKS_PER_BIT - 1));
  // middle of the start bit
  assign mid_start_w = (clk_cnt_r == UART_CLK_CNT_W'((CLKS_PER_BIT - 1) / 2));

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_r    <= RX_IDLE;
      clk_cnt_r  <= '0;
      bit_idx_r  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state_r)
        RX_IDLE: begin
          clk_cnt_r <= '0;
          bit_idx_r <= '0;
          if (!rx_sync_r) begin
            state_r <= RX_START;
          end
        end
        RX_START: begin
          // recheck at mid-bit, from here on every sample is mid-bit
          if (mid_start_w) begin
            clk_cnt_r <= '0;
            state_r   <= rx_sync_r ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt_r <= clk_cnt_r + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end_w) begin
            clk_cnt_r <= '0;
            bit_idx_r <= bit_idx_r + 1'b1;
            if (bit_idx_r == UART_BIT_IDX_W'(UART_DATA_BITS - 1)) begin
              state_r <= RX_STOP;
            end
          end else begin
            clk_cnt_r <= clk_cnt_r + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end_w) begin
            // strobe only on a good stop bit
            rx_valid_o <= rx_sync_r;
            clk_cnt_r  <= '0;
            state_r    <= RX_IDLE;
          end else begin
            clk_cnt_r <= clk_cnt_r + 1'b1;
          end
        end
        default: state_r <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first, shift in from the top
  always_ff @(posedge fpga_clk) begin
    if ((state_r == RX_DATA) && bit_end_w) begin
      rx_byte_o <= {rx_sync_r, rx_byte_o[UART_DATA_BITS-1:1]};
    end
  end

endmodule

// ==== uart_tx.sv ====
// 8N1 only; tx_start is ignored while a frame is on the line
// a frame takes 10 * CLKS_PER_BIT cycles, busy covers all of it
`timescale 1ns/10ps
module uart_tx
  import uart_pkg::*;
(
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       tx_start_i,
  input  uart_byte_t tx_byte_i,
  output logic       tx_serial_o,
  output logic       tx_busy_o
);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t                 state_r;
  logic [UART_CLK_CNT_W-1:0] clk_cnt_r;
  logic [UART_BIT_IDX_W-1:0] bit_idx_r;
  uart_byte_t                shift_r;
  logic                      bit_end_w;

  assign bit_end_w = (clk_cnt_r == UART_CLK_CNT_W'(CLKS_PER_BIT - 1));
  assign tx_busy_o = (state_r != TX_IDLE);

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_r     <= TX_IDLE;
      clk_cnt_r   <= '0;
      bit_idx_r   <= '0;
      tx_serial_o <= 1'b1;
    end else begin
      case (state_r)
        TX_IDLE: begin
          clk_cnt_r <= '0;
          bit_idx_r <= '0;
          if (tx_start_i) begin
            // start bit goes out next cycle
            tx_serial_o <= 1'b0;
            state_r     <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end_w) begin
            clk_cnt_r   <= '0;
            tx_serial_o <= shift_r[0];
            state_r     <= TX_DATA;
          end else begin
            clk_cnt_r <= clk_cnt_r + 1'b1;
          end
        end
        TX_DATA: begin
          if (bit_end_w) begin
            clk_cnt_r <= '0;
            bit_idx_r <= bit_idx_r + 1'b1;
            if (bit_idx_r == UART_BIT_IDX_W'(UART_DATA_BITS - 1)) begin
              // stop bit
              tx_serial_o <= 1'b1;
              state_r     <= TX_STOP;
            end else begin
              tx_serial_o <= shift_r[1];
            end
          end else begin
            clk_cnt_r <= clk_cnt_r + 1'b1;
          end
        end
        TX_STOP: begin
          // line stays high into idle
          if (bit_end_w) begin
            clk_cnt_r <= '0;
            state_r   <= TX_IDLE;
          end else begin
            clk_cnt_r <= clk_cnt_r + 1'b1;
          end
        end
        default: state_r <= TX_IDLE;
      endcase
    end
  end

  // byte latched on start, shifted LSB first
  always_ff @(posedge fpga_clk) begin
    if ((state_r == TX_IDLE) && tx_start_i) begin
      shift_r <= tx_byte_i;
    end else if ((state_r == TX_DATA) && bit_end_w) begin
      shift_r <= shift_r >> 1;
    end
  end

endmodule
